/* source/main_consts.svh */
`ifndef MAIN_CONSTS_SVH
`define MAIN_CONSTS_SVH

`define MAIN_ADDR_W 8
`define MAIN_DATA_W 16

// register offsets, word aligned
`define REG_JOY  8'h00
`define REG_SYS  8'h04
`define REG_DIP  8'h08
`define REG_ROT1 8'h0C
`define REG_ROT2 8'h10
`define REG_SND  8'h14
`define REG_MCU  8'h18
`define REG_PRI  8'h1C
`define REG_MIX  8'h20
`define REG_VCLR 8'h24

`define DISP_BASE  8'h80   // any address with bit 7 set
`define DISP_DELAY 2       // cycles from blank to pready

`define IRQ_LVL_VBL 3'd6
`define IRQ_LVL_SEC 3'd5
`define IRQ_LVL_EXT 3'd4

`define ROT_DIV_W 3
`define ROT_W     12
`define OPEN_BUS  16'hFFFF

`endif

/* source/main_bus_pkg.sv */
`include "main_consts.svh"

package main_bus_pkg;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`MAIN_ADDR_W-1:0] paddr;
        logic [`MAIN_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                    pready;
        logic [`MAIN_DATA_W-1:0] prdata;
    } apb_rsp_t;

    // one cycle selects, only on the completing access
    typedef struct packed {
        logic joy;
        logic sys;
        logic dip;
        logic rot1;
        logic rot2;
        logic snd;
        logic mcu_wr;   // mailbox has both directions
        logic mcu_rd;
        logic pri;
        logic mix;
        logic vclr;
        logic disp;
    } sel_t;

endpackage

/* source/main_io_pkg.sv */
`include "main_consts.svh"

package main_io_pkg;

    // cabinet switches, active low as on the board
    typedef struct packed {
        logic [8:0] joystick1;
        logic [8:0] joystick2;
        logic [1:0] start_button;
        logic [1:0] coin_input;
        logic       service;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

    typedef struct packed {
        logic [7:0]              snd_latch;
        logic                    snreq;    // sound cpu strobe
        logic [`MAIN_DATA_W-1:0] mcu_din;
        logic                    mcu_wr;
        logic                    mcu_rd;
        logic [2:0]              prisel;   // colour priority
        logic                    mixpsel;  // object dma mix
    } latch_out_t;

endpackage

/* source/main_ctrl.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  main_bus_pkg::apb_req_t  bus_req,
    output main_bus_pkg::apb_rsp_t  bus_rsp,
    input  logic                    lvbl,
    input  logic                    lhbl,
    input  logic [`MAIN_DATA_W-1:0] cab_word,
    output logic [2:0]              cab_rsel,
    input  logic [`MAIN_DATA_W-1:0] mcu_dout,
    input  logic [`MAIN_DATA_W-1:0] disp_dout,
    output main_bus_pkg::sel_t      sel,
    output logic                    disp_cs
);
    localparam int CNT_W = $clog2(`DISP_DELAY + 1);

    logic             access;
    logic             is_disp;
    logic             blank;
    logic             blank_seen;
    logic [CNT_W-1:0] wait_cnt;
    logic             disp_rdy;
    logic             wr;

    assign access   = bus_req.psel & bus_req.penable;
    assign is_disp  = |(bus_req.paddr & `DISP_BASE);
    assign blank    = ~lvbl | ~lhbl;
    assign wr       = bus_req.pwrite;
    assign disp_cs  = access & is_disp;
    assign disp_rdy = blank_seen && (wait_cnt == '0);
    assign cab_rsel = bus_req.paddr[4:2];   // word index of the cabinet registers

    // registers answer at once, the display window waits for a blank
    assign bus_rsp.pready = access & (~is_disp | disp_rdy);

    // display wait: first blank cycle inside the access starts the count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_seen <= 1'b0;
            wait_cnt   <= '0;
        end else if (bus_rsp.pready) begin
            blank_seen <= 1'b0;
            wait_cnt   <= '0;
        end else if (disp_cs && !blank_seen && blank) begin
            blank_seen <= 1'b1;
            wait_cnt   <= CNT_W'(`DISP_DELAY - 1);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    always_comb begin
        bus_rsp.prdata = `OPEN_BUS;
        if (is_disp) begin
            bus_rsp.prdata = disp_dout;
        end else begin
            case (bus_req.paddr)
                `REG_JOY, `REG_SYS, `REG_DIP,
                `REG_ROT1, `REG_ROT2: bus_rsp.prdata = cab_word;
                `REG_MCU:             bus_rsp.prdata = mcu_dout;
                default:              bus_rsp.prdata = `OPEN_BUS;
            endcase
        end
    end

    // selects fire on the completing cycle only
    always_comb begin
        sel = '0;
        if (bus_rsp.pready) begin
            if (is_disp) begin
                sel.disp = 1'b1;
            end else begin
                case (bus_req.paddr)
                    `REG_JOY:  sel.joy  = ~wr;
                    `REG_SYS:  sel.sys  = ~wr;
                    `REG_DIP:  sel.dip  = ~wr;
                    `REG_ROT1: sel.rot1 = ~wr;
                    `REG_ROT2: sel.rot2 = ~wr;
                    `REG_SND:  sel.snd  = wr;
                    `REG_MCU: begin
                        sel.mcu_wr = wr;
                        sel.mcu_rd = ~wr;   // read also acks the sub cpu irq
                    end
                    `REG_PRI:  sel.pri  = wr;
                    `REG_MIX:  sel.mix  = wr;
                    `REG_VCLR: sel.vclr = wr;
                    default:   sel = '0;
                endcase
            end
        end
    end

endmodule

/* source/main_regs.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  main_bus_pkg::sel_t           sel,
    input  logic [`MAIN_DATA_W-1:0]      pwdata,
    output main_io_pkg::latch_out_t      latch
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            latch <= '0;
        end else begin
            // strobes last one cycle, right after the access
            latch.snreq  <= sel.snd;
            latch.mcu_wr <= sel.mcu_wr;
            latch.mcu_rd <= sel.mcu_rd;

            if (sel.snd)
                latch.snd_latch <= pwdata[7:0];   // low byte only

            if (sel.mcu_wr)
                latch.mcu_din <= pwdata;

            if (sel.pri)
                latch.prisel <= pwdata[2:0];

            if (sel.mix)
                latch.mixpsel <= pwdata[0];
        end
    end

endmodule

/* source/main_cabinet.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_cabinet (
    input  logic                    clk,
    input  logic                    rst,
    input  main_io_pkg::cab_in_t    cab,
    input  logic                    lvbl,
    input  logic [2:0]              cab_rsel,
    output logic [`MAIN_DATA_W-1:0] cab_word
);
    localparam int PAD_W = `MAIN_DATA_W - `ROT_W;

    logic [8:0]            sort1;
    logic [8:0]            sort2;
    logic                  lvbl_l;
    logic [`ROT_DIV_W-1:0] frame_cnt;
    logic [`ROT_W-1:0]     rot1;
    logic [`ROT_W-1:0]     rot2;

    // direction nibble is wired backwards on the harness
    function automatic logic [8:0] sort_joy(input logic [8:0] joy);
        sort_joy = {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    // one-hot dial, right (bit 7) wins over left (bit 6)
    function automatic logic [`ROT_W-1:0] rot_step(input logic [`ROT_W-1:0] pos,
                                                   input logic [8:0]        joy);
        rot_step = pos;
        if (!joy[7])
            rot_step = (pos == '0) ? {1'b1, {(`ROT_W-1){1'b0}}} : pos >> 1;
        else if (!joy[6])
            rot_step = (pos == '0) ? `ROT_W'(1) : pos << 1;
    endfunction

    assign sort1 = sort_joy(cab.joystick1);
    assign sort2 = sort_joy(cab.joystick2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            rot1      <= '0;
            rot2      <= '0;
        end else begin
            lvbl_l <= lvbl;
            if (lvbl_l && !lvbl) begin   // start of vblank
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_cnt == '0) begin
                    rot1 <= rot_step(rot1, cab.joystick1);
                    rot2 <= rot_step(rot2, cab.joystick2);
                end
            end
        end
    end

    always_comb begin
        case ({3'b000, cab_rsel, 2'b00})
            `REG_JOY:  cab_word = {sort2[7:0], sort1[7:0]};
            `REG_SYS:  cab_word = {8'hFF, ~lvbl, cab.service, cab.coin_input,
                                   cab.start_button, sort2[8], sort1[8]};
            `REG_DIP:  cab_word = {cab.dipsw_b, cab.dipsw_a};
            `REG_ROT1: cab_word = {{PAD_W{1'b1}}, ~rot1};   // dial reads inverted
            `REG_ROT2: cab_word = {{PAD_W{1'b1}}, ~rot2};
            default:   cab_word = `OPEN_BUS;
        endcase
    end

endmodule

/* source/main_irq.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_irq (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       sec2,
    input  logic       nexirq,
    input  logic       vclr,
    input  logic       secclr,
    output logic [2:0] ipl
);

    logic lvbl_l;
    logic sec2_l;
    logic vbl_irq;
    logic sec_irq;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l  <= 1'b0;
            sec2_l  <= 1'b0;
            vbl_irq <= 1'b0;
            sec_irq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            sec2_l <= sec2;

            if (vclr)                      // clear beats a new edge
                vbl_irq <= 1'b0;
            else if (lvbl_l && !lvbl)
                vbl_irq <= 1'b1;

            if (secclr)
                sec_irq <= 1'b0;
            else if (!sec2_l && sec2)      // sub cpu raises sec2
                sec_irq <= 1'b1;
        end
    end

    always_comb begin
        if (vbl_irq)
            ipl = `IRQ_LVL_VBL;
        else if (sec_irq)
            ipl = `IRQ_LVL_SEC;
        else if (!nexirq)   // external line is active low
            ipl = `IRQ_LVL_EXT;
        else
            ipl = 3'd0;
    end

endmodule

/* source/main_top.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_top (
    input  logic                    clk,
    input  logic                    rst,
    input  main_bus_pkg::apb_req_t  bus_req,
    output main_bus_pkg::apb_rsp_t  bus_rsp,
    input  main_io_pkg::cab_in_t    cab,
    input  logic                    lvbl,
    input  logic                    lhbl,
    input  logic                    nexirq,
    input  logic                    sec2,
    input  logic [`MAIN_DATA_W-1:0] mcu_dout,
    input  logic [`MAIN_DATA_W-1:0] disp_dout,
    output main_io_pkg::latch_out_t latch,
    output logic                    disp_cs,
    output logic [2:0]              ipl
);

    main_bus_pkg::sel_t      sel;
    logic [`MAIN_DATA_W-1:0] cab_word;
    logic [2:0]              cab_rsel;

    main_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .lvbl      (lvbl),
        .lhbl      (lhbl),
        .cab_word  (cab_word),
        .cab_rsel  (cab_rsel),
        .mcu_dout  (mcu_dout),
        .disp_dout (disp_dout),
        .sel       (sel),
        .disp_cs   (disp_cs)
    );

    main_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .sel    (sel),
        .pwdata (bus_req.pwdata),
        .latch  (latch)
    );

    main_cabinet u_cabinet (
        .clk      (clk),
        .rst      (rst),
        .cab      (cab),
        .lvbl     (lvbl),
        .cab_rsel (cab_rsel),
        .cab_word (cab_word)
    );

    // mailbox read acknowledges the sub cpu interrupt
    main_irq u_irq (
        .clk    (clk),
        .rst    (rst),
        .lvbl   (lvbl),
        .sec2   (sec2),
        .nexirq (nexirq),
        .vclr   (sel.vclr),
        .secclr (sel.mcu_rd),
        .ipl    (ipl)
    );

endmodule

/* bench/main_checker.sv */
`timescale 1ns/1ps

module main_checker (
    input logic                    clk,
    input logic                    rst,
    input main_bus_pkg::apb_req_t  bus_req,
    input main_bus_pkg::apb_rsp_t  bus_rsp,
    input main_io_pkg::latch_out_t latch,
    input logic                    disp_cs,
    input logic [2:0]              ipl
);

    logic stalled;

    assign stalled = bus_req.psel & bus_req.penable & ~bus_rsp.pready;   // access in a wait state

    // master holds address, data and control through wait states
    req_stable: assert property (@(posedge clk) disable iff (rst) stalled |=> $stable(bus_req))
        else $error("request changed while the access was waiting");

    ipl_range: assert property (@(posedge clk) disable iff (rst) ipl != 3'd7)
        else $error("ipl reached level 7");

    snreq_pulse: assert property (@(posedge clk) disable iff (rst) latch.snreq |=> !latch.snreq)
        else $error("snreq stayed high for more than one cycle");

    // display select may only drop once the access has completed
    disp_hold: assert property (@(posedge clk) disable iff (rst)
                                (disp_cs && !bus_rsp.pready) |=> disp_cs)
        else $error("disp_cs fell before pready");

endmodule

bind main_top main_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .latch   (latch),
    .disp_cs (disp_cs),
    .ipl     (ipl)
);

/* bench/main_tb.sv */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_tb;

    typedef enum logic [2:0] {OP_RD, OP_WR, OP_FRAME, OP_SEC, OP_IPL, OP_EXT} op_t;

    typedef struct packed {
        op_t         op;
        logic [7:0]  addr;
        logic [15:0] data;
        logic [15:0] expect_val;
    } step_t;

    localparam int          FRAME_CYC = 7;                  // one lvbl pulse plus a spare cycle
    localparam int          MAX_WAIT  = `DISP_DELAY + 8;    // longest display wait in this run
    localparam logic [15:0] MCU_WORD  = 16'hC3A5;
    localparam logic [15:0] DISP_WORD = 16'h5EED;

    logic                    clk;
    logic                    rst;
    main_bus_pkg::apb_req_t  bus_req;
    main_bus_pkg::apb_rsp_t  bus_rsp;
    main_io_pkg::cab_in_t    cab;
    main_io_pkg::cab_in_t    cab_val;
    logic                    lvbl;
    logic                    lhbl;
    logic                    nexirq;
    logic                    sec2;
    logic [15:0]             mcu_dout;
    logic [15:0]             disp_dout;
    main_io_pkg::latch_out_t latch;
    logic                    disp_cs;
    logic [2:0]              ipl;

    step_t       steps[$];
    integer      seed;
    int          errors;
    int          checks;
    int          cycle;
    int          limit;
    int          first_cyc;
    int          ready_cyc;
    int          blank_cyc;
    int          snreq_cnt;
    int          mcu_wr_cnt;
    int          mcu_rd_cnt;
    int          exp_snreq;
    int          exp_mcu_wr;
    int          exp_mcu_rd;
    logic        first_cs;
    logic [15:0] rdata;

    main_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .cab       (cab),
        .lvbl      (lvbl),
        .lhbl      (lhbl),
        .nexirq    (nexirq),
        .sec2      (sec2),
        .mcu_dout  (mcu_dout),
        .disp_dout (disp_dout),
        .latch     (latch),
        .disp_cs   (disp_cs),
        .ipl       (ipl)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("run timed out after %0d cycles, a transfer never completed", cycle);
            $display("Errors found");
            $finish;
        end
    end

    // count strobe pulses once per high cycle
    always @(negedge clk) begin
        if (latch.snreq)
            snreq_cnt++;
        if (latch.mcu_wr)
            mcu_wr_cnt++;
        if (latch.mcu_rd)
            mcu_rd_cnt++;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // low nibble of each stick is wired in reverse
    function automatic logic [8:0] reorder_stick(input logic [8:0] raw);
        logic [8:0] res;
        int         b;
        res = raw;
        for (b = 0; b < 4; b++)
            res[b] = raw[3 - b];
        return res;
    endfunction

    function automatic logic [15:0] latch_field(input logic [7:0] addr);
        case (addr)
            `REG_SND: return {8'd0, latch.snd_latch};
            `REG_MCU: return latch.mcu_din;
            `REG_PRI: return {13'd0, latch.prisel};
            `REG_MIX: return {15'd0, latch.mixpsel};
            default:  return `OPEN_BUS;
        endcase
    endfunction

    function automatic string field_name(input logic [7:0] addr);
        case (addr)
            `REG_SND: return "latch.snd_latch";
            `REG_MCU: return "latch.mcu_din";
            `REG_PRI: return "latch.prisel";
            `REG_MIX: return "latch.mixpsel";
            default:  return "latch";
        endcase
    endfunction

    task automatic add_step(input op_t op, input logic [7:0] addr, input logic [15:0] data,
                            input logic [15:0] expect_val);
        steps.push_back('{op, addr, data, expect_val});
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rd);
        @(posedge clk);
        bus_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        bus_req.penable <= 1'b1;
        @(negedge clk);
        first_cyc = cycle;
        first_cs  = disp_cs;
        while (!bus_rsp.pready)
            @(negedge clk);
        ready_cyc = cycle;
        rd = bus_rsp.prdata;
        @(posedge clk);   // completing edge
        bus_req <= '0;
    endtask

    task automatic vblank_pulse;
        @(posedge clk);
        lvbl <= 1'b0;
        repeat (3) @(posedge clk);
        lvbl <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic sec2_pulse;
        @(posedge clk);
        sec2 <= 1'b1;
        repeat (2) @(posedge clk);
        sec2 <= 1'b0;
    endtask

    // stick 1 holds left for the dial while stick 2 stays centred
    task automatic randomize_cabinet;
        logic [31:0] r;
        r = $random(seed);
        cab_val.joystick1    = {r[8], 2'b10, r[5:0]};
        cab_val.joystick2    = {r[17], 2'b11, r[14:9]};
        cab_val.start_button = r[19:18];
        cab_val.coin_input   = r[21:20];
        cab_val.service      = r[22];
        r = $random(seed);
        cab_val.dipsw_a = r[7:0];
        cab_val.dipsw_b = r[15:8];
    endtask

    task automatic build_steps;
        logic [8:0] s1;
        logic [8:0] s2;
        int         i;
        s1 = reorder_stick(cab_val.joystick1);
        s2 = reorder_stick(cab_val.joystick2);
        add_step(OP_RD, 8'h28, '0, `OPEN_BUS);   // unmapped
        add_step(OP_RD, 8'h7E, '0, `OPEN_BUS);
        add_step(OP_RD, `REG_JOY, '0, {s2[7:0], s1[7:0]});
        add_step(OP_RD, `REG_SYS, '0, {8'hFF, 1'b0, cab_val.service, cab_val.coin_input,
                                       cab_val.start_button, s2[8], s1[8]});
        add_step(OP_RD, `REG_DIP, '0, {cab_val.dipsw_b, cab_val.dipsw_a});
        add_step(OP_RD, `REG_ROT1, '0, 16'hFFFF);
        add_step(OP_RD, `REG_ROT2, '0, 16'hFFFF);
        add_step(OP_WR, `REG_SND, 16'hA55A, 16'h005A);
        add_step(OP_WR, `REG_PRI, 16'h00FD, 16'h0005);
        add_step(OP_WR, `REG_MIX, 16'h0003, 16'h0001);
        add_step(OP_WR, `REG_MIX, 16'h0002, 16'h0000);
        add_step(OP_WR, `REG_MCU, 16'h1234, 16'h1234);
        add_step(OP_WR, `REG_SND, 16'h0081, 16'h0081);
        // dial steps on frames 1 and 9 only
        for (i = 1; i <= 16; i++) begin
            add_step(OP_FRAME, '0, '0, '0);
            if (i == 1 || i == 8)
                add_step(OP_RD, `REG_ROT1, '0, 16'hFFFE);
            if (i == 9 || i == 16)
                add_step(OP_RD, `REG_ROT1, '0, 16'hFFFD);
        end
        add_step(OP_RD, `REG_ROT2, '0, 16'hFFFF);
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_VBL));
        add_step(OP_WR, `REG_VCLR, '0, '0);
        add_step(OP_IPL, '0, '0, '0);
        add_step(OP_EXT, '0, 16'h0000, '0);   // nexirq low
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_EXT));
        add_step(OP_SEC, '0, '0, '0);
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_SEC));
        add_step(OP_RD, `REG_MCU, '0, MCU_WORD);
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_EXT));
        add_step(OP_FRAME, '0, '0, '0);
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_VBL));
        add_step(OP_WR, `REG_VCLR, '0, '0);
        add_step(OP_IPL, '0, '0, 16'(`IRQ_LVL_EXT));
        add_step(OP_EXT, '0, 16'h0001, '0);
        add_step(OP_IPL, '0, '0, '0);
    endtask

    task automatic run_step(input step_t s);
        logic [15:0] rd;
        case (s.op)
            OP_RD: begin
                apb_xfer(1'b0, s.addr, '0, rd);
                check($sformatf("prdata@%02h", s.addr), 32'(rd), 32'(s.expect_val));
                if (s.addr == `REG_MCU)
                    exp_mcu_rd++;
            end
            OP_WR: begin
                apb_xfer(1'b1, s.addr, s.data, rd);
                @(negedge clk);
                if (s.addr != `REG_VCLR)
                    check(field_name(s.addr), 32'(latch_field(s.addr)), 32'(s.expect_val));
                if (s.addr == `REG_SND)
                    exp_snreq++;
                if (s.addr == `REG_MCU)
                    exp_mcu_wr++;
            end
            OP_FRAME: vblank_pulse();
            OP_SEC:   sec2_pulse();
            OP_IPL: begin
                @(negedge clk);
                check("ipl", 32'(ipl), 32'(s.expect_val));
            end
            OP_EXT: begin
                @(posedge clk);
                nexirq <= s.data[0];
                @(posedge clk);
            end
            default: begin
                errors++;
                $display("step table holds an unknown operation %0d", s.op);
            end
        endcase
    endtask

    initial begin
        seed      = 32'hb0c5;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        bus_req   = '0;
        cab       = '1;
        lvbl      = 1'b1;
        lhbl      = 1'b1;
        nexirq    = 1'b1;
        sec2      = 1'b0;
        mcu_dout  = MCU_WORD;
        disp_dout = DISP_WORD;
        randomize_cabinet();
        build_steps();
        // room for every step at the longest wait plus one frame
        limit = (steps.size() + 4) * (MAX_WAIT + FRAME_CYC) + 20;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        cab <= cab_val;
        @(negedge clk);
        check("latch.snd_latch", 32'(latch.snd_latch), '0);
        check("latch.snreq", 32'(latch.snreq), '0);
        check("latch.mcu_din", 32'(latch.mcu_din), '0);
        check("latch.mcu_wr", 32'(latch.mcu_wr), '0);
        check("latch.mcu_rd", 32'(latch.mcu_rd), '0);
        check("latch.prisel", 32'(latch.prisel), '0);
        check("latch.mixpsel", 32'(latch.mixpsel), '0);
        check("ipl", 32'(ipl), '0);
        check("pready", 32'(bus_rsp.pready), '0);
        check("disp_cs", 32'(disp_cs), '0);

        foreach (steps[i])
            run_step(steps[i]);

        // display read with the line blank starting mid access
        fork
            apb_xfer(1'b0, 8'hA6, '0, rdata);
            begin
                repeat (5) @(posedge clk);
                lhbl <= 1'b0;
                @(negedge clk);
                blank_cyc = cycle;
            end
        join
        check("prdata@a6", 32'(rdata), 32'(DISP_WORD));
        check("disp_cs", 32'(first_cs), 32'd1);
        check("pready delay after blank", ready_cyc - blank_cyc, `DISP_DELAY);

        // blank already active so the count runs from the first access cycle
        apb_xfer(1'b1, 8'h80, 16'h0BAD, rdata);
        check("disp_cs", 32'(first_cs), 32'd1);
        check("pready delay in blank", ready_cyc - first_cyc, `DISP_DELAY);
        @(posedge clk);
        lhbl <= 1'b1;

        repeat (3) @(posedge clk);
        check("snreq pulses", snreq_cnt, exp_snreq);
        check("mcu_wr pulses", mcu_wr_cnt, exp_mcu_wr);
        check("mcu_rd pulses", mcu_rd_cnt, exp_mcu_rd);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/main_bus_pkg.sv
source/main_io_pkg.sv
source/main_ctrl.sv
source/main_regs.sv
source/main_cabinet.sv
source/main_irq.sv
source/main_top.sv
bench/main_checker.sv
bench/main_tb.sv

/* Makefile */
SRCS := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmain_tb: files.f $(SRCS)
	verilator --binary --timing --assert --top-module main_tb -f files.f -o Vmain_tb

sim.log: obj_dir/Vmain_tb
	./obj_dir/Vmain_tb > sim.log 2>&1; cat sim.log

run: sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
